//--- hdl/isa_pkg.sv
package isa_pkg;

	localparam int opcode_width = 4;
	localparam int func_width = 6;
	localparam int imm_width = 8;
	localparam int target_width = 12;

	// Opcodes
	localparam logic [opcode_width-1:0] op_bne = 4'd0;
	localparam logic [opcode_width-1:0] op_beq = 4'd1;
	localparam logic [opcode_width-1:0] op_adi = 4'd4;
	localparam logic [opcode_width-1:0] op_ori = 4'd5;
	localparam logic [opcode_width-1:0] op_lhi = 4'd6;
	localparam logic [opcode_width-1:0] op_lwd = 4'd7;
	localparam logic [opcode_width-1:0] op_swd = 4'd8;
	localparam logic [opcode_width-1:0] op_jmp = 4'd9;
	localparam logic [opcode_width-1:0] op_jal = 4'd10;
	localparam logic [opcode_width-1:0] op_rtype = 4'd15;

	// Function codes of the R-type group
	localparam logic [func_width-1:0] fn_add = 6'd0;
	localparam logic [func_width-1:0] fn_sub = 6'd1;
	localparam logic [func_width-1:0] fn_and = 6'd2;
	localparam logic [func_width-1:0] fn_orr = 6'd3;
	localparam logic [func_width-1:0] fn_wwd = 6'd28;
	localparam logic [func_width-1:0] fn_hlt = 6'd29;

	typedef logic [1:0] reg_addr_t;

	// One instruction word, read as R, I or J format
	typedef union packed {
		struct packed {
			logic [opcode_width-1:0] opcode;
			reg_addr_t rs;
			reg_addr_t rt;
			reg_addr_t rd;
			logic [func_width-1:0] func;
		} r;
		struct packed {
			logic [opcode_width-1:0] opcode;
			reg_addr_t rs;
			reg_addr_t rt;
			logic [imm_width-1:0] imm;
		} i;
		struct packed {
			logic [opcode_width-1:0] opcode;
			logic [target_width-1:0] target;
		} j;
	} inst_t;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

	localparam int word_width = 16;
	localparam int num_regs = 4;

	// Operand source in execute
	localparam logic [1:0] fwd_reg = 2'd0;
	localparam logic [1:0] fwd_mem = 2'd1;
	localparam logic [1:0] fwd_wb = 2'd2;

	// ALU operations
	localparam logic [2:0] alu_add = 3'd0;
	localparam logic [2:0] alu_sub = 3'd1;
	localparam logic [2:0] alu_and = 3'd2;
	localparam logic [2:0] alu_or = 3'd3;
	localparam logic [2:0] alu_lhi = 3'd4;
	localparam logic [2:0] alu_pass_a = 3'd5;

	localparam logic [1:0] link_reg = 2'd2; // JAL destination

endpackage

//--- hdl/control_unit.sv
module control_unit import isa_pkg::*, pipe_pkg::*; (
	input inst_t inst,
	output logic [2:0] alu_op,
	output logic alu_src,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output reg_addr_t dest,
	output logic is_branch,
	output logic is_jump,
	output logic is_link,
	output logic is_wwd,
	output logic is_hlt,
	output logic uses_rt,
	output logic [word_width-1:0] imm_ext
);

	always_comb begin
		alu_op = alu_add;
		alu_src = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		dest = inst.i.rt; // I-type default
		is_branch = 1'b0;
		is_jump = 1'b0;
		is_link = 1'b0;
		is_wwd = 1'b0;
		is_hlt = 1'b0;
		uses_rt = 1'b0;
		imm_ext = {{(word_width-imm_width){inst.i.imm[imm_width-1]}}, inst.i.imm};

		case (inst.r.opcode)
			op_rtype: begin
				dest = inst.r.rd;
				case (inst.r.func)
					fn_add, fn_sub, fn_and, fn_orr: begin
						reg_write = 1'b1;
						uses_rt = 1'b1;
						alu_op = (inst.r.func == fn_add) ? alu_add :
							(inst.r.func == fn_sub) ? alu_sub :
							(inst.r.func == fn_and) ? alu_and : alu_or;
					end
					fn_wwd: begin
						is_wwd = 1'b1;
						alu_op = alu_pass_a; // rs rides to writeback as the result
					end
					fn_hlt: is_hlt = 1'b1;
					default: ;
				endcase
			end
			op_adi: begin
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			op_ori: begin
				alu_op = alu_or;
				alu_src = 1'b1;
				reg_write = 1'b1;
				imm_ext = {{(word_width-imm_width){1'b0}}, inst.i.imm}; // Zero extended
			end
			op_lhi: begin
				alu_op = alu_lhi;
				alu_src = 1'b1;
				reg_write = 1'b1;
			end
			op_lwd: begin
				alu_src = 1'b1;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			op_swd: begin
				alu_src = 1'b1;
				mem_write = 1'b1;
				uses_rt = 1'b1; // Store data
			end
			op_bne, op_beq: begin
				is_branch = 1'b1;
				uses_rt = 1'b1;
			end
			op_jmp, op_jal: begin
				is_jump = 1'b1;
				imm_ext = {{(word_width-target_width){1'b0}}, inst.j.target};
				if (inst.j.opcode == op_jal) begin
					is_link = 1'b1;
					reg_write = 1'b1;
					dest = link_reg;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/register_file.sv
module register_file import isa_pkg::*, pipe_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_addr_t rd_addr1,
	input reg_addr_t rd_addr2,
	input logic wr_en,
	input reg_addr_t wr_addr,
	input logic [word_width-1:0] wr_data,
	output logic [word_width-1:0] rd_data1,
	output logic [word_width-1:0] rd_data2
);

	logic [word_width-1:0] regs [num_regs];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Writeback in the same cycle is visible to decode
	assign rd_data1 = (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
	assign rd_data2 = (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

	wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_addr));

endmodule

//--- hdl/hazard_unit.sv
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
	input reg_addr_t id_rs,
	input reg_addr_t id_rt,
	input logic id_uses_rt,
	input logic ex_valid,
	input logic ex_mem_read,
	input reg_addr_t ex_dest,
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input logic mem_valid,
	input logic mem_reg_write,
	input reg_addr_t mem_dest,
	input logic wb_valid,
	input logic wb_reg_write,
	input reg_addr_t wb_dest,
	output logic stall,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b
);

	logic mem_hit_a;
	logic mem_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	// Load result is not ready until it reaches writeback
	assign stall = ex_valid && ex_mem_read &&
		((ex_dest == id_rs) || (id_uses_rt && ex_dest == id_rt));

	assign mem_hit_a = mem_valid && mem_reg_write && (mem_dest == ex_rs);
	assign mem_hit_b = mem_valid && mem_reg_write && (mem_dest == ex_rt);
	assign wb_hit_a = wb_valid && wb_reg_write && (wb_dest == ex_rs);
	assign wb_hit_b = wb_valid && wb_reg_write && (wb_dest == ex_rt);

	// Younger producer wins
	always_comb begin
		fwd_a = fwd_reg;
		fwd_b = fwd_reg;
		if (mem_hit_a)
			fwd_a = fwd_mem;
		else if (wb_hit_a)
			fwd_a = fwd_wb;
		if (mem_hit_b)
			fwd_b = fwd_mem;
		else if (wb_hit_b)
			fwd_b = fwd_wb;
	end

endmodule

//--- hdl/alu.sv
module alu import pipe_pkg::*; (
	input logic [word_width-1:0] a,
	input logic [word_width-1:0] b,
	input logic [2:0] alu_op,
	output logic [word_width-1:0] result,
	output logic equal
);

	localparam int half = word_width / 2;

	always_comb begin
		case (alu_op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_lhi: result = {b[half-1:0], {half{1'b0}}}; // Immediate into upper byte
			alu_pass_a: result = a;
			default: result = '0;
		endcase
	end

	// Branch condition for BEQ and BNE
	assign equal = (a == b);

endmodule

//--- hdl/cpu.sv
module cpu import isa_pkg::*, pipe_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic [word_width-1:0] inst_addr,
	input inst_t inst_data,
	output logic [word_width-1:0] data_addr,
	output logic [word_width-1:0] data_wdata,
	input logic [word_width-1:0] data_rdata,
	output logic data_read,
	output logic data_write,
	output logic [word_width-1:0] output_port,
	output logic [word_width-1:0] num_inst,
	output logic is_halted
);

	logic [word_width-1:0] pc, pc_next;
	logic stall, taken, halting;

	logic id_valid;
	inst_t id_inst;
	logic [word_width-1:0] id_pc;
	logic [2:0] id_alu_op;
	logic id_alu_src, id_mem_read, id_mem_write, id_reg_write;
	reg_addr_t id_dest;
	logic id_is_branch, id_is_jump, id_is_link, id_is_wwd, id_is_hlt, id_uses_rt;
	logic [word_width-1:0] id_imm, id_rdata1, id_rdata2;

	logic ex_valid;
	logic [2:0] ex_alu_op;
	logic ex_alu_src, ex_load, ex_store, ex_reg_write;
	reg_addr_t ex_dest, ex_rs, ex_rt;
	logic ex_is_branch, ex_is_beq, ex_is_jump, ex_is_link, ex_is_wwd, ex_is_hlt;
	logic [word_width-1:0] ex_pc, ex_imm, ex_data1, ex_data2;
	logic [1:0] fwd_a, fwd_b;
	logic [word_width-1:0] ex_a, ex_b_reg, ex_b, alu_result, ex_result, ex_target;
	logic alu_equal, ex_taken;

	logic mem_valid, mem_load, mem_store, mem_reg_write, mem_is_wwd, mem_is_hlt, mem_taken;
	reg_addr_t mem_dest;
	logic [word_width-1:0] mem_result, mem_wdata, mem_target;

	logic wb_valid, wb_load, wb_reg_write, wb_is_wwd, wb_is_hlt;
	reg_addr_t wb_dest;
	logic [word_width-1:0] wb_result, wb_rdata, wb_value;

	function automatic logic [word_width-1:0] select_operand(input logic [1:0] sel,
		input logic [word_width-1:0] reg_val, input logic [word_width-1:0] mem_val,
		input logic [word_width-1:0] wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// HLT in writeback stops everything behind it at once
	assign halting = is_halted || (wb_valid && wb_is_hlt);
	assign taken = mem_valid && mem_taken;

	always_comb begin
		if (halting)
			pc_next = pc;
		else if (taken)
			pc_next = mem_target;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc + 1'b1;
	end

	assign inst_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			id_valid <= 1'b0;
			ex_valid <= 1'b0;
			mem_valid <= 1'b0;
			wb_valid <= 1'b0;
			is_halted <= 1'b0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			pc <= pc_next;
			if (halting || taken)
				id_valid <= 1'b0;
			else if (!stall)
				id_valid <= 1'b1;
			ex_valid <= id_valid && !stall && !taken && !halting; // Bubble on stall
			mem_valid <= ex_valid && !taken && !halting;
			wb_valid <= mem_valid && !halting;
			if (wb_valid && wb_is_hlt)
				is_halted <= 1'b1;
			if (wb_valid)
				num_inst <= num_inst + 1'b1;
			if (wb_valid && wb_is_wwd)
				output_port <= wb_result;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_inst <= inst_data;
			id_pc <= pc;
		end
	end

	control_unit control_unit_inst (
		.inst(id_inst), .alu_op(id_alu_op), .alu_src(id_alu_src),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .reg_write(id_reg_write),
		.dest(id_dest), .is_branch(id_is_branch), .is_jump(id_is_jump),
		.is_link(id_is_link), .is_wwd(id_is_wwd), .is_hlt(id_is_hlt),
		.uses_rt(id_uses_rt), .imm_ext(id_imm)
	);

	register_file register_file_inst (
		.clk(clk), .rst_n(rst_n),
		.rd_addr1(id_inst.r.rs), .rd_addr2(id_inst.r.rt),
		.wr_en(wb_valid && wb_reg_write), .wr_addr(wb_dest), .wr_data(wb_value),
		.rd_data1(id_rdata1), .rd_data2(id_rdata2)
	);

	always_ff @(posedge clk) begin
		ex_alu_op <= id_alu_op;
		ex_alu_src <= id_alu_src;
		ex_load <= id_mem_read;
		ex_store <= id_mem_write;
		ex_reg_write <= id_reg_write;
		ex_dest <= id_dest;
		ex_rs <= id_inst.r.rs;
		ex_rt <= id_inst.r.rt;
		ex_is_branch <= id_is_branch;
		ex_is_beq <= (id_inst.r.opcode == op_beq);
		ex_is_jump <= id_is_jump;
		ex_is_link <= id_is_link;
		ex_is_wwd <= id_is_wwd;
		ex_is_hlt <= id_is_hlt;
		ex_pc <= id_pc;
		ex_imm <= id_imm;
		ex_data1 <= id_rdata1;
		ex_data2 <= id_rdata2;
	end

	hazard_unit hazard_unit_inst (
		.id_rs(id_inst.r.rs), .id_rt(id_inst.r.rt), .id_uses_rt(id_uses_rt),
		.ex_valid(ex_valid), .ex_mem_read(ex_load), .ex_dest(ex_dest),
		.ex_rs(ex_rs), .ex_rt(ex_rt),
		.mem_valid(mem_valid), .mem_reg_write(mem_reg_write), .mem_dest(mem_dest),
		.wb_valid(wb_valid), .wb_reg_write(wb_reg_write), .wb_dest(wb_dest),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	assign ex_a = select_operand(fwd_a, ex_data1, mem_result, wb_value);
	assign ex_b_reg = select_operand(fwd_b, ex_data2, mem_result, wb_value);
	assign ex_b = ex_alu_src ? ex_imm : ex_b_reg;

	alu alu_inst (
		.a(ex_a), .b(ex_b), .alu_op(ex_alu_op), .result(alu_result), .equal(alu_equal)
	);

	assign ex_result = ex_is_link ? ex_pc + 1'b1 : alu_result; // JAL link value
	assign ex_target = ex_is_jump ? {ex_pc[word_width-1:target_width], ex_imm[target_width-1:0]}
		: ex_pc + 1'b1 + ex_imm;
	assign ex_taken = ex_is_jump || (ex_is_branch && (ex_is_beq == alu_equal));

	always_ff @(posedge clk) begin
		mem_load <= ex_load;
		mem_store <= ex_store;
		mem_reg_write <= ex_reg_write;
		mem_dest <= ex_dest;
		mem_is_wwd <= ex_is_wwd;
		mem_is_hlt <= ex_is_hlt;
		mem_taken <= ex_taken;
		mem_target <= ex_target;
		mem_result <= ex_result;
		mem_wdata <= ex_b_reg; // Forwarded rt for SWD
	end

	assign data_addr = mem_result;
	assign data_wdata = mem_wdata;
	assign data_read = mem_valid && mem_load;
	assign data_write = mem_valid && mem_store && !(wb_valid && wb_is_hlt);

	always_ff @(posedge clk) begin
		wb_load <= mem_load;
		wb_reg_write <= mem_reg_write;
		wb_dest <= mem_dest;
		wb_is_wwd <= mem_is_wwd;
		wb_is_hlt <= mem_is_hlt;
		wb_result <= mem_result;
		wb_rdata <= data_rdata;
	end

	assign wb_value = wb_load ? wb_rdata : wb_result;

	no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_read && data_write));
	no_write_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
		is_halted |-> !data_write);

endmodule

//--- bench/cpu_tb.sv
module cpu_tb import isa_pkg::*, pipe_pkg::*; ();

	localparam int timeout_cycles = 200;
	localparam int reset_cycles = 16;
	localparam int hold_cycles = 20;
	localparam int mem_depth = 256;
	localparam logic [word_width-1:0] store_addr = 16'h0019; // r2 = 7 + 10h, offset 2

	logic clk = 1'b0;
	logic rst_n;
	logic [word_width-1:0] inst_addr;
	inst_t inst_data;
	logic [word_width-1:0] data_addr;
	logic [word_width-1:0] data_wdata;
	logic [word_width-1:0] data_rdata;
	logic data_read;
	logic data_write;
	logic [word_width-1:0] output_port;
	logic [word_width-1:0] num_inst;
	logic is_halted;

	inst_t imem [mem_depth];
	logic [word_width-1:0] dmem [mem_depth];

	// Program table
	inst_t prog_inst [$];
	bit prog_wwd [$];
	logic [word_width-1:0] prog_value [$];
	bit prog_retire [$];

	cpu cpu_inst (
		.clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .inst_data(inst_data),
		.data_addr(data_addr), .data_wdata(data_wdata), .data_rdata(data_rdata),
		.data_read(data_read), .data_write(data_write), .output_port(output_port),
		.num_inst(num_inst), .is_halted(is_halted)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (data_write)
			dmem[data_addr[7:0]] <= data_wdata;
	end

	// Read data follows the address edge by one unit
	always @(posedge clk) begin
		#1;
		inst_data = imem[inst_addr[7:0]];
		data_rdata = data_read ? dmem[data_addr[7:0]] : '0; // Data only on a real read
	end

	function automatic inst_t encode_r(input reg_addr_t rs, rt, rd, input logic [5:0] func);
		return {op_rtype, rs, rt, rd, func};
	endfunction

	function automatic inst_t encode_i(input logic [3:0] op, input reg_addr_t rs, rt,
		input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic inst_t encode_j(input logic [3:0] op, input logic [11:0] target);
		return {op, target};
	endfunction

	task automatic add_row(input inst_t word, input bit wwd,
		input logic [word_width-1:0] value, input bit retire);
		prog_inst.push_back(word);
		prog_wwd.push_back(wwd);
		prog_value.push_back(value);
		prog_retire.push_back(retire);
	endtask

	task automatic add_step(input inst_t word);
		add_row(word, 1'b0, '0, 1'b1);
	endtask

	task automatic add_wwd(input reg_addr_t rs, input logic [word_width-1:0] value);
		add_row(encode_r(rs, 2'd0, 2'd0, fn_wwd), 1'b1, value, 1'b1);
	endtask

	// Never retires when the flow is steered right
	task automatic add_guard(input reg_addr_t rs);
		add_row(encode_r(rs, 2'd0, 2'd0, fn_wwd), 1'b0, '0, 1'b0);
	endtask

	task automatic build_program();
		add_step(encode_i(op_adi, 2'd0, 2'd1, 8'h05)); // r1 = 5
		add_step(encode_i(op_adi, 2'd1, 2'd2, 8'hfe)); // r2 = 5 - 2
		add_step(encode_r(2'd1, 2'd2, 2'd3, fn_add)); // r3 = 5 + 3
		add_wwd(2'd3, 16'h0008);
		add_step(encode_r(2'd2, 2'd1, 2'd0, fn_sub)); // r0 = 3 - 5
		add_wwd(2'd0, 16'hfffe);
		add_step(encode_r(2'd0, 2'd1, 2'd3, fn_and)); // r3 = fffe & 5
		add_step(encode_r(2'd3, 2'd2, 2'd3, fn_orr)); // r3 = 4 | 3
		add_wwd(2'd3, 16'h0007);
		add_step(encode_i(op_lhi, 2'd0, 2'd1, 8'h12)); // r1 = 1200
		add_step(encode_i(op_ori, 2'd1, 2'd1, 8'h84)); // Zero extended immediate
		add_wwd(2'd1, 16'h1284);
		// Store and load back, then use the load at once
		add_step(encode_i(op_adi, 2'd3, 2'd2, 8'h10)); // r2 = 17
		add_step(encode_i(op_swd, 2'd2, 2'd1, 8'h02));
		add_step(encode_i(op_lwd, 2'd2, 2'd0, 8'h02));
		add_step(encode_i(op_adi, 2'd0, 2'd0, 8'h01));
		add_wwd(2'd0, 16'h1285);
		add_step(encode_i(op_beq, 2'd0, 2'd0, 8'h03)); // Taken to row 21
		add_guard(2'd1);
		add_guard(2'd2);
		add_guard(2'd3);
		add_step(encode_i(op_bne, 2'd1, 2'd1, 8'h05)); // Falls through
		add_step(encode_i(op_adi, 2'd3, 2'd3, 8'h20)); // r3 = 7 + 20h
		add_wwd(2'd3, 16'h0027);
		add_step(encode_j(op_jmp, 12'd28));
		add_guard(2'd1);
		add_guard(2'd2);
		add_guard(2'd0);
		add_step(encode_j(op_jal, 12'd32)); // Link value 28 + 1
		add_guard(2'd1);
		add_guard(2'd0);
		add_guard(2'd1);
		add_wwd(link_reg, 16'h001d);
		add_step(encode_r(2'd0, 2'd0, 2'd0, fn_hlt));
	endtask

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input logic [word_width-1:0] got, expected, input string what);
		if (got !== expected) begin
			$display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
			stop_run();
		end
	endtask

	task automatic check_bit(input logic got, expected, input string what);
		if (got !== expected) begin
			$display("Error at time %0t: %s is %b, expected %b", $time, what, got, expected);
			stop_run();
		end
	endtask

	task automatic check_idle(input string when, input logic [word_width-1:0] expected_pc);
		check_bit(is_halted, 1'b0, {"is_halted ", when});
		check_word(num_inst, '0, {"num_inst ", when});
		check_word(output_port, '0, {"output_port ", when});
		check_bit(data_read, 1'b0, {"data_read ", when});
		check_bit(data_write, 1'b0, {"data_write ", when});
		check_word(inst_addr, expected_pc, {"inst_addr ", when});
	endtask

	task automatic wait_output_change(input logic [word_width-1:0] last);
		int cycles;
		cycles = 0;
		while (output_port === last && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (output_port === last) begin
			$display("timeout waiting for output_port change");
			stop_run();
		end
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (is_halted !== 1'b1 && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (is_halted !== 1'b1) begin
			$display("timeout waiting for halt");
			stop_run();
		end
	endtask

	initial begin
		logic [word_width-1:0] retired;
		logic [word_width-1:0] last_value;
		rst_n = 1'b0;
		inst_data = '0;
		data_rdata = '0;
		build_program();
		for (int a = 0; a < mem_depth; a++) begin
			if (a < prog_inst.size())
				imem[a] = prog_inst[a];
			else
				imem[a] = {4'd3, 4'd0, a[7:0]}; // Opcode 3 is unused
			dmem[a] = {~a[7:0], a[7:0]};
		end

		repeat (reset_cycles) @(posedge clk);
		#1;
		check_idle("in reset", '0);
		rst_n = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_idle("after reset", 16'd1); // First fetch done, nothing retired yet

		last_value = '0;
		for (int r = 0; r < prog_inst.size(); r++) begin
			if (prog_wwd[r]) begin
				wait_output_change(last_value);
				check_word(output_port, prog_value[r], $sformatf("output_port at row %0d", r));
				last_value = prog_value[r];
			end
		end

		wait_halt();
		retired = '0;
		foreach (prog_retire[r])
			if (prog_retire[r])
				retired = retired + 1'b1;
		check_word(num_inst, retired, "num_inst at halt");
		check_word(dmem[store_addr[7:0]], 16'h1284, "stored word");

		repeat (hold_cycles) begin
			@(negedge clk);
			check_bit(is_halted, 1'b1, "is_halted after halt");
			check_word(output_port, last_value, "output_port after halt");
			check_word(num_inst, retired, "num_inst after halt");
			check_bit(data_write, 1'b0, "data_write after halt");
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- cpu.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/alu.sv
hdl/cpu.sv
bench/cpu_tb.sv
